/* hw/vec_macros.svh */
`ifndef VEC_MACROS_SVH
`define VEC_MACROS_SVH

// Lane organization
`define VEC_NR_LANES       4
`define VEC_ELEMS_PER_LANE 4
`define VEC_NR_VREGS       4
// Must equal lanes times elements per lane
`define VEC_VLEN           16
`define VEC_ELEN           32

// AXI4-Lite slave widths
`define VEC_AXI_ADDR_W     12
`define VEC_AXI_DATA_W     32

// Register map above the element region
`define VEC_ADDR_CMD       12'h100
`define VEC_ADDR_STATUS    12'h104
`define VEC_ADDR_RED       12'h108

`endif

/* hw/vec_pkg.sv */
`include "vec_macros.svh"

package vec_pkg;

  // Index widths derived from the lane organization
  localparam int unsigned lane_w = $clog2(`VEC_NR_LANES);
  localparam int unsigned slot_w = $clog2(`VEC_ELEMS_PER_LANE);
  localparam int unsigned vreg_w = $clog2(`VEC_NR_VREGS);

  // Configuration sanity checks reported at elaboration of the top
  localparam bit cfg_lanes_ok  = (`VEC_NR_LANES > 0) && (`VEC_NR_LANES == 2 ** lane_w);
  localparam bit cfg_vlen_ok   = `VEC_VLEN == `VEC_NR_LANES * `VEC_ELEMS_PER_LANE;
  localparam bit cfg_width_ok  = `VEC_ELEN == `VEC_AXI_DATA_W;

  // AXI response codes
  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

  typedef logic [`VEC_ELEN-1:0] elem_t;

  typedef enum logic [2:0] {
    VOP_ADD = 3'd0,
    VOP_SUB = 3'd1,
    VOP_AND = 3'd2,
    VOP_OR  = 3'd3,
    VOP_XOR = 3'd4,
    VOP_MUL = 3'd5
  } vec_op_e;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WRESP,
    ST_RWAIT,
    ST_RRESP
  } disp_state_e;

  typedef enum logic [1:0] {
    LK_WRITE,
    LK_READ,
    LK_EXEC
  } lane_kind_e;

  // Broadcast to every lane while the valid mask picks the target
  typedef struct packed {
    lane_kind_e        kind;
    logic [slot_w-1:0] slot;
    logic [vreg_w-1:0] vd;
    logic [vreg_w-1:0] vs1;
    logic [vreg_w-1:0] vs2;
    vec_op_e           op;
    elem_t             wdata;
  } lane_req_t;

  typedef struct packed {
    logic  valid;
    elem_t data;
  } lane_rsp_t;

  typedef struct packed {
    logic  valid;
    logic  last;
    elem_t data;
  } lane_res_t;

endpackage

/* hw/vec_dispatcher.sv */
`include "vec_macros.svh"

module vec_dispatcher import vec_pkg::*; (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  // AXI4-Lite slave
  input  logic [`VEC_AXI_ADDR_W-1:0]    awaddr_i,
  input  logic                          awvalid_i,
  output logic                          awready_o,
  input  logic [`VEC_AXI_DATA_W-1:0]    wdata_i,
  input  logic [`VEC_AXI_DATA_W/8-1:0]  wstrb_i,
  input  logic                          wvalid_i,
  output logic                          wready_o,
  output logic [1:0]                    bresp_o,
  output logic                          bvalid_o,
  input  logic                          bready_i,
  input  logic [`VEC_AXI_ADDR_W-1:0]    araddr_i,
  input  logic                          arvalid_i,
  output logic                          arready_o,
  output logic [`VEC_AXI_DATA_W-1:0]    rdata_o,
  output logic [1:0]                    rresp_o,
  output logic                          rvalid_o,
  input  logic                          rready_i,
  // Lanes
  output lane_req_t                     lane_req_o,
  output logic [`VEC_NR_LANES-1:0]      lane_req_valid_o,
  input  lane_rsp_t [`VEC_NR_LANES-1:0] lane_rsp_i,
  // Reducer
  input  logic                          red_done_i,
  input  elem_t                         red_sum_i
);

  // Bit positions of the element fields in a byte address
  localparam int unsigned lane_lsb = 2;
  localparam int unsigned slot_lsb = lane_lsb + lane_w;
  localparam int unsigned vreg_lsb = slot_lsb + slot_w;

  disp_state_e                  state_q;
  logic                         busy_q;
  elem_t                        red_sum_q;
  logic [lane_w-1:0]            rd_lane_q;
  logic [`VEC_AXI_DATA_W-1:0]   rdata_q;
  logic [1:0]                   rresp_q;
  logic [1:0]                   bresp_q;

  logic rd_go, wr_go;
  logic ar_elem, aw_elem, aw_cmd, aw_status, aw_red;
  logic cmd_legal;
  logic rd_elem, wr_elem, wr_exec, wr_ok;

  //////////////////////////////
  // Handshake and decode
  //////////////////////////////

  // Reads win over writes when both wait in idle
  assign rd_go     = (state_q == ST_IDLE) && arvalid_i;
  assign wr_go     = (state_q == ST_IDLE) && awvalid_i && wvalid_i && !arvalid_i;
  assign arready_o = rd_go;
  assign awready_o = wr_go;
  assign wready_o  = wr_go;

  assign ar_elem   = araddr_i[`VEC_AXI_ADDR_W-1:8] == '0;
  assign aw_elem   = awaddr_i[`VEC_AXI_ADDR_W-1:8] == '0;
  assign aw_cmd    = awaddr_i == `VEC_ADDR_CMD;
  assign aw_status = awaddr_i == `VEC_ADDR_STATUS;
  assign aw_red    = awaddr_i == `VEC_ADDR_RED;
  assign cmd_legal = wdata_i[2:0] <= 3'(VOP_MUL);

  assign rd_elem = rd_go && ar_elem && !busy_q;
  assign wr_elem = wr_go && aw_elem && !busy_q;
  assign wr_exec = wr_go && aw_cmd && cmd_legal && !busy_q;
  // Status and reduction accept writes and drop them
  assign wr_ok   = wr_elem || wr_exec || aw_status || aw_red;

  //////////////////////////////
  // Lane requests
  //////////////////////////////

  always_comb begin
    lane_req_o       = '0;
    lane_req_valid_o = '0;
    if (rd_elem) begin
      lane_req_o.kind = LK_READ;
      lane_req_o.slot = araddr_i[slot_lsb +: slot_w];
      lane_req_o.vd   = araddr_i[vreg_lsb +: vreg_w];
      lane_req_valid_o[araddr_i[lane_lsb +: lane_w]] = 1'b1;
    end else if (wr_elem) begin
      lane_req_o.kind  = LK_WRITE;
      lane_req_o.slot  = awaddr_i[slot_lsb +: slot_w];
      lane_req_o.vd    = awaddr_i[vreg_lsb +: vreg_w];
      lane_req_o.wdata = wdata_i;
      lane_req_valid_o[awaddr_i[lane_lsb +: lane_w]] = 1'b1;
    end else if (wr_exec) begin
      // All lanes start together
      lane_req_o.kind  = LK_EXEC;
      lane_req_o.vd    = wdata_i[4 +: vreg_w];
      lane_req_o.vs1   = wdata_i[8 +: vreg_w];
      lane_req_o.vs2   = wdata_i[12 +: vreg_w];
      lane_req_o.op    = vec_op_e'(wdata_i[2:0]);
      lane_req_valid_o = '1;
    end
  end

  //////////////////////////////
  // FSM
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q   <= ST_IDLE;
      busy_q    <= 1'b0;
      red_sum_q <= '0;
      rd_lane_q <= '0;
      rdata_q   <= '0;
      rresp_q   <= resp_okay;
      bresp_q   <= resp_okay;
    end else begin
      // Instruction retired
      if (red_done_i) begin
        busy_q    <= 1'b0;
        red_sum_q <= red_sum_i;
      end
      case (state_q)
        ST_IDLE: begin
          if (rd_go) begin
            rdata_q <= '0;
            rresp_q <= resp_okay;
            state_q <= ST_RRESP;
            if (rd_elem) begin
              rd_lane_q <= araddr_i[lane_lsb +: lane_w];
              state_q   <= ST_RWAIT;
            end else if (ar_elem) begin
              rresp_q <= resp_slverr;
            end else if (araddr_i == `VEC_ADDR_STATUS) begin
              rdata_q <= `VEC_AXI_DATA_W'(busy_q);
            end else if (araddr_i == `VEC_ADDR_RED) begin
              rdata_q <= red_sum_q;
            end else begin
              rresp_q <= resp_slverr;
            end
          end else if (wr_go) begin
            bresp_q <= wr_ok ? resp_okay : resp_slverr;
            state_q <= ST_WRESP;
            if (wr_exec) begin
              busy_q <= 1'b1;
            end
          end
        end
        ST_WRESP: begin
          if (bready_i) begin
            state_q <= ST_IDLE;
          end
        end
        ST_RWAIT: begin
          if (lane_rsp_i[rd_lane_q].valid) begin
            rdata_q <= lane_rsp_i[rd_lane_q].data;
            state_q <= ST_RRESP;
          end
        end
        ST_RRESP: begin
          if (rready_i) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  assign bvalid_o = state_q == ST_WRESP;
  assign bresp_o  = bresp_q;
  assign rvalid_o = state_q == ST_RRESP;
  assign rresp_o  = rresp_q;
  assign rdata_o  = rdata_q;

endmodule

/* hw/vec_lane.sv */
`include "vec_macros.svh"

module vec_lane import vec_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  lane_req_t req_i,
  input  logic      req_valid_i,
  output lane_rsp_t rsp_o,
  output lane_res_t res_o
);

  // This lane's slice of every vector register
  elem_t vrf_q [`VEC_NR_VREGS][`VEC_ELEMS_PER_LANE];

  lane_req_t         exe_q;
  logic              running_q;
  logic [slot_w-1:0] slot_cnt_q;
  logic              slot_last;
  logic              rsp_valid_q;
  elem_t             rsp_data_q;

  logic  req_write, req_read, req_exec;
  elem_t op_a, op_b, alu_res;

  assign req_write = req_valid_i && (req_i.kind == LK_WRITE);
  assign req_read  = req_valid_i && (req_i.kind == LK_READ);
  assign req_exec  = req_valid_i && (req_i.kind == LK_EXEC);

  //////////////////////////////
  // Element ALU
  //////////////////////////////

  assign op_a      = vrf_q[exe_q.vs1][slot_cnt_q];
  assign op_b      = vrf_q[exe_q.vs2][slot_cnt_q];
  assign slot_last = slot_cnt_q == slot_w'(`VEC_ELEMS_PER_LANE - 1);

  always_comb begin
    case (exe_q.op)
      VOP_ADD: alu_res = op_a + op_b;
      VOP_SUB: alu_res = op_a - op_b;
      VOP_AND: alu_res = op_a & op_b;
      VOP_OR:  alu_res = op_a | op_b;
      VOP_XOR: alu_res = op_a ^ op_b;
      // Low half of the product only
      VOP_MUL: alu_res = op_a * op_b;
      default: alu_res = '0;
    endcase
  end

  //////////////////////////////
  // Register file
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (req_write) begin
      vrf_q[req_i.vd][req_i.slot] <= req_i.wdata;
    end else if (running_q) begin
      vrf_q[exe_q.vd][slot_cnt_q] <= alu_res;
    end
    if (req_read) begin
      rsp_data_q <= vrf_q[req_i.vd][req_i.slot];
    end
    if (req_exec) begin
      exe_q <= req_i;
    end
  end

  // Execute walks the slots one per cycle
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      running_q   <= 1'b0;
      slot_cnt_q  <= '0;
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= req_read;
      if (req_exec) begin
        running_q  <= 1'b1;
        slot_cnt_q <= '0;
      end else if (running_q) begin
        slot_cnt_q <= slot_cnt_q + 1'b1;
        if (slot_last) begin
          running_q <= 1'b0;
        end
      end
    end
  end

  assign rsp_o = '{valid: rsp_valid_q, data: rsp_data_q};

  // Each result leaves in the cycle it is computed
  assign res_o = '{valid: running_q, last: running_q && slot_last, data: alu_res};

endmodule

/* hw/vec_reduce.sv */
`include "vec_macros.svh"

module vec_reduce import vec_pkg::*; (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  lane_res_t [`VEC_NR_LANES-1:0] res_i,
  output logic                          done_o,
  output elem_t                         sum_o
);

  // Heap ordered adder tree with leaves at the top indices
  elem_t [2*`VEC_NR_LANES-2:0] tree_sum;

  logic  first_q;
  logic  done_q;
  elem_t acc_q;
  logic  res_valid, res_last;

  // Lanes run in lockstep so lane 0 speaks for all
  assign res_valid = res_i[0].valid;
  assign res_last  = res_i[0].last;

  always_comb begin
    for (int i = 0; i < `VEC_NR_LANES; i++) begin
      tree_sum[`VEC_NR_LANES-1+i] = res_i[i].data;
    end
    for (int i = `VEC_NR_LANES - 2; i >= 0; i--) begin
      tree_sum[i] = tree_sum[2*i+1] + tree_sum[2*i+2];
    end
  end

  //////////////////////////////
  // Accumulator
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      first_q <= 1'b1;
      done_q  <= 1'b0;
      acc_q   <= '0;
    end else begin
      done_q <= res_valid && res_last;
      if (res_valid) begin
        // Restart on the first beat of a new instruction
        acc_q   <= first_q ? tree_sum[0] : acc_q + tree_sum[0];
        first_q <= res_last;
      end
    end
  end

  assign done_o = done_q;
  assign sum_o  = acc_q;

endmodule

/* hw/vec_top.sv */
`include "vec_macros.svh"

module vec_top import vec_pkg::*; (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  // AXI4-Lite slave
  input  logic [`VEC_AXI_ADDR_W-1:0]   awaddr_i,
  input  logic                         awvalid_i,
  output logic                         awready_o,
  input  logic [`VEC_AXI_DATA_W-1:0]   wdata_i,
  input  logic [`VEC_AXI_DATA_W/8-1:0] wstrb_i,
  input  logic                         wvalid_i,
  output logic                         wready_o,
  output logic [1:0]                   bresp_o,
  output logic                         bvalid_o,
  input  logic                         bready_i,
  input  logic [`VEC_AXI_ADDR_W-1:0]   araddr_i,
  input  logic                         arvalid_i,
  output logic                         arready_o,
  output logic [`VEC_AXI_DATA_W-1:0]   rdata_o,
  output logic [1:0]                   rresp_o,
  output logic                         rvalid_o,
  input  logic                         rready_i
);

  lane_req_t                      lane_req;
  logic      [`VEC_NR_LANES-1:0]  lane_req_valid;
  lane_rsp_t [`VEC_NR_LANES-1:0]  lane_rsp;
  lane_res_t [`VEC_NR_LANES-1:0]  lane_res;
  logic                           red_done;
  elem_t                          red_sum;

  //////////////////////////////
  // Dispatcher
  //////////////////////////////

  vec_dispatcher i_dispatcher (
    .clk_i            (clk_i         ),
    .rst_n_i          (rst_n_i       ),
    .awaddr_i         (awaddr_i      ),
    .awvalid_i        (awvalid_i     ),
    .awready_o        (awready_o     ),
    .wdata_i          (wdata_i       ),
    .wstrb_i          (wstrb_i       ),
    .wvalid_i         (wvalid_i      ),
    .wready_o         (wready_o      ),
    .bresp_o          (bresp_o       ),
    .bvalid_o         (bvalid_o      ),
    .bready_i         (bready_i      ),
    .araddr_i         (araddr_i      ),
    .arvalid_i        (arvalid_i     ),
    .arready_o        (arready_o     ),
    .rdata_o          (rdata_o       ),
    .rresp_o          (rresp_o       ),
    .rvalid_o         (rvalid_o      ),
    .rready_i         (rready_i      ),
    .lane_req_o       (lane_req      ),
    .lane_req_valid_o (lane_req_valid),
    .lane_rsp_i       (lane_rsp      ),
    .red_done_i       (red_done      ),
    .red_sum_i        (red_sum       )
  );

  //////////////////////////////
  // Lanes
  //////////////////////////////

  for (genvar l = 0; l < `VEC_NR_LANES; l++) begin : gen_lanes
    vec_lane i_lane (
      .clk_i       (clk_i            ),
      .rst_n_i     (rst_n_i          ),
      .req_i       (lane_req         ),
      .req_valid_i (lane_req_valid[l]),
      .rsp_o       (lane_rsp[l]      ),
      .res_o       (lane_res[l]      )
    );
  end : gen_lanes

  // Sum reduction of the last result
  vec_reduce i_reduce (
    .clk_i   (clk_i   ),
    .rst_n_i (rst_n_i ),
    .res_i   (lane_res),
    .done_o  (red_done),
    .sum_o   (red_sum )
  );

  // Elaboration checks on the macro set
  if (!cfg_lanes_ok)
    $error("[vec_top] Lane count must be a nonzero power of two");

  if (!cfg_vlen_ok)
    $error("[vec_top] VLEN must equal lanes times elements per lane");

  if (!cfg_width_ok)
    $error("[vec_top] Element width must match the AXI data width");

endmodule

/* tb/vec_top_assertions.sv */
`include "vec_macros.svh"

module vec_top_assertions import vec_pkg::*; (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          bvalid_i,
  input  logic                          bready_i,
  input  logic [1:0]                    bresp_i,
  input  logic                          rvalid_i,
  input  logic                          rready_i,
  input  logic [1:0]                    rresp_i,
  input  logic [`VEC_AXI_DATA_W-1:0]    rdata_i,
  input  lane_res_t [`VEC_NR_LANES-1:0] lane_res_i
);

  int unsigned fail_cnt = 0;

  logic [`VEC_NR_LANES-1:0] res_valid;
  logic [`VEC_NR_LANES-1:0] res_last;

  always_comb begin
    for (int l = 0; l < `VEC_NR_LANES; l++) begin
      res_valid[l] = lane_res_i[l].valid;
      res_last[l]  = lane_res_i[l].last;
    end
  end

  //////////////////////////////
  // AXI response channels
  //////////////////////////////

  b_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    bvalid_i && !bready_i |=> bvalid_i && $stable(bresp_i))
    else begin
      $error("B channel changed while stalled");
      fail_cnt++;
    end

  r_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rvalid_i && !rready_i |=> rvalid_i && $stable(rresp_i) && $stable(rdata_i))
    else begin
      $error("R channel changed while stalled");
      fail_cnt++;
    end

  // Quiet during reset and in the first cycle out of it
  reset_quiet: assert property (@(posedge clk_i)
    !rst_n_i || $rose(rst_n_i) |-> !bvalid_i && !rvalid_i && (res_valid == '0))
    else begin
      $error("Valid output high after reset");
      fail_cnt++;
    end

  //////////////////////////////
  // Lane lockstep
  //////////////////////////////

  lanes_lockstep: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (res_valid == '0 || res_valid == '1) && (res_last == '0 || res_last == '1))
    else begin
      $error("Lane result streams out of step");
      fail_cnt++;
    end

endmodule

/* tb/tb_vec_top.sv */
`include "vec_macros.svh"

module tb_vec_top import vec_pkg::*; ();

  localparam int timeout_cycles = 200;

  logic                         clk_i;
  logic                         rst_n_i;
  logic [`VEC_AXI_ADDR_W-1:0]   awaddr_i;
  logic [`VEC_AXI_ADDR_W-1:0]   araddr_i;
  logic                         awvalid_i, wvalid_i, bready_i, arvalid_i, rready_i;
  logic [`VEC_AXI_DATA_W-1:0]   wdata_i;
  logic [`VEC_AXI_DATA_W/8-1:0] wstrb_i;
  logic                         awready_o, wready_o, bvalid_o, arready_o, rvalid_o;
  logic [1:0]                   bresp_o;
  logic [1:0]                   rresp_o;
  logic [`VEC_AXI_DATA_W-1:0]   rdata_o;

  logic [31:0] lfsr_q;
  logic [31:0] shadow [`VEC_NR_VREGS][`VEC_VLEN];
  logic        bp_en;
  int          check_cnt, mismatch_cnt, timeout_cnt;
  string       what_q[$];
  logic [31:0] got_q[$];
  logic [31:0] exp_q[$];

  vec_top dut_i (.*);

  bind vec_top vec_top_assertions i_assertions (
    .clk_i      (clk_i   ),
    .rst_n_i    (rst_n_i ),
    .bvalid_i   (bvalid_o),
    .bready_i   (bready_i),
    .bresp_i    (bresp_o ),
    .rvalid_i   (rvalid_o),
    .rready_i   (rready_i),
    .rresp_i    (rresp_o ),
    .rdata_i    (rdata_o ),
    .lane_res_i (lane_res)
  );

  always #2 clk_i = ~clk_i;

  //////////////////////////////
  // Stimulus and reference
  //////////////////////////////

  // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
  function automatic logic [31:0] rand_bits(input int nbits);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < nbits; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      val    = {val[30:0], fb};
    end
    return val;
  endfunction

  function automatic logic [31:0] ref_alu(input logic [2:0] op, input logic [31:0] a, b);
    case (op)
      3'd0: return a + b;
      3'd1: return a - b;
      3'd2: return a & b;
      3'd3: return a | b;
      3'd4: return a ^ b;
      // Low 32 bits of the product
      3'd5: return a * b;
      default: return '0;
    endcase
  endfunction

  // Updates the shadow register file and returns the expected reduction
  function automatic logic [31:0] apply_ref(input logic [2:0] op,
                                            input logic [1:0] vd, vs1, vs2);
    logic [31:0] res [`VEC_VLEN];
    logic [31:0] sum;
    sum = '0;
    for (int e = 0; e < `VEC_VLEN; e++) begin
      res[e] = ref_alu(op, shadow[vs1][e], shadow[vs2][e]);
      sum    = sum + res[e];
    end
    for (int e = 0; e < `VEC_VLEN; e++) begin
      shadow[vd][e] = res[e];
    end
    return sum;
  endfunction

  function automatic logic [11:0] elem_addr(input int vreg, input int e);
    return {4'b0, vreg[1:0], e[3:0], 2'b00};
  endfunction

  function automatic logic [31:0] cmd_word(input logic [2:0] op, input logic [1:0] vd, vs1, vs2);
    return {18'b0, vs2, 2'b0, vs1, 2'b0, vd, 1'b0, op};
  endfunction

  //////////////////////////////
  // Checking
  //////////////////////////////

  task automatic check_value(input string what, input logic [31:0] got, exp);
    check_cnt++;
    if (got !== exp) begin
      mismatch_cnt++;
      $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic expect_eq(input string what, input logic [31:0] got, exp);
    what_q.push_back(what);
    got_q.push_back(got);
    exp_q.push_back(exp);
  endtask

  always @(negedge clk_i) begin
    while (got_q.size() > 0) begin
      check_value(what_q.pop_front(), got_q.pop_front(), exp_q.pop_front());
    end
  end

  task automatic report_counts();
    $display("Summary: %0d checks, %0d mismatches, %0d timeouts, %0d assertion failures",
             check_cnt, mismatch_cnt, timeout_cnt, dut_i.i_assertions.fail_cnt);
  endtask

  task automatic time_out(input string what);
    timeout_cnt++;
    $display("Timeout at %0t while waiting for %s", $time, what);
    report_counts();
    $display("Test failed");
    $finish;
  endtask

  //////////////////////////////
  // AXI4-Lite driver
  //////////////////////////////

  // Tasks start and end just after a falling edge
  task automatic wait_bresp(output logic [1:0] resp);
    int hold;
    int cnt;
    hold     = bp_en ? int'(rand_bits(3)) : 0;
    cnt      = 0;
    bready_i = (hold == 0);
    #1;
    while (!(bvalid_o && bready_i)) begin
      if (bvalid_o && hold > 0) hold--;
      cnt++;
      if (cnt > timeout_cycles) time_out("B response");
      @(negedge clk_i);
      bready_i = (hold == 0);
      #1;
    end
    resp = bresp_o;
    @(negedge clk_i);
    bready_i = 1'b0;
  endtask

  task automatic wait_rresp(output logic [31:0] data, output logic [1:0] resp);
    int hold;
    int cnt;
    hold     = bp_en ? int'(rand_bits(3)) : 0;
    cnt      = 0;
    rready_i = (hold == 0);
    #1;
    while (!(rvalid_o && rready_i)) begin
      if (rvalid_o && hold > 0) hold--;
      cnt++;
      if (cnt > timeout_cycles) time_out("R response");
      @(negedge clk_i);
      rready_i = (hold == 0);
      #1;
    end
    data = rdata_o;
    resp = rresp_o;
    @(negedge clk_i);
    rready_i = 1'b0;
  endtask

  task automatic axi_write(input logic [11:0] addr, input logic [31:0] data,
                           output logic [1:0] resp);
    int cnt;
    cnt       = 0;
    awaddr_i  = addr;
    wdata_i   = data;
    awvalid_i = 1'b1;
    wvalid_i  = 1'b1;
    #1;
    while (!(awready_o && wready_o)) begin
      cnt++;
      if (cnt > timeout_cycles) time_out("AW and W ready");
      @(negedge clk_i);
      #1;
    end
    @(negedge clk_i);
    awvalid_i = 1'b0;
    wvalid_i  = 1'b0;
    wait_bresp(resp);
  endtask

  task automatic axi_read(input logic [11:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    int cnt;
    cnt       = 0;
    araddr_i  = addr;
    arvalid_i = 1'b1;
    #1;
    while (!arready_o) begin
      cnt++;
      if (cnt > timeout_cycles) time_out("AR ready");
      @(negedge clk_i);
      #1;
    end
    @(negedge clk_i);
    arvalid_i = 1'b0;
    wait_rresp(data, resp);
  endtask

  //////////////////////////////
  // Sequences
  //////////////////////////////

  task automatic write_elem(input int vreg, input int e, input logic [31:0] data);
    logic [1:0] resp;
    axi_write(elem_addr(vreg, e), data, resp);
    expect_eq($sformatf("write v%0d[%0d] resp", vreg, e), resp, resp_okay);
    shadow[vreg][e] = data;
  endtask

  task automatic check_reg(input int vreg);
    logic [31:0] data;
    logic [1:0]  resp;
    for (int e = 0; e < `VEC_VLEN; e++) begin
      axi_read(elem_addr(vreg, e), data, resp);
      expect_eq($sformatf("v%0d[%0d]", vreg, e), data, shadow[vreg][e]);
      expect_eq($sformatf("read v%0d[%0d] resp", vreg, e), resp, resp_okay);
    end
  endtask

  task automatic wait_idle();
    logic [31:0] data;
    logic [1:0]  resp;
    int          cnt;
    cnt = 0;
    axi_read(`VEC_ADDR_STATUS, data, resp);
    while (data[0]) begin
      cnt++;
      if (cnt > timeout_cycles) time_out("busy to clear");
      axi_read(`VEC_ADDR_STATUS, data, resp);
    end
    expect_eq("status resp", resp, resp_okay);
  endtask

  task automatic run_cmd(input logic [2:0] op, input logic [1:0] vd, vs1, vs2);
    logic [31:0] data;
    logic [1:0]  resp;
    logic [31:0] sum;
    axi_write(`VEC_ADDR_CMD, cmd_word(op, vd, vs1, vs2), resp);
    expect_eq($sformatf("op %0d command resp", op), resp, resp_okay);
    wait_idle();
    sum = apply_ref(op, vd, vs1, vs2);
    axi_read(`VEC_ADDR_RED, data, resp);
    expect_eq($sformatf("sum after op %0d", op), data, sum);
    check_reg(vd);
  endtask

  initial begin
    logic [31:0] data;
    logic [1:0]  resp;
    logic [31:0] sum;
    logic [1:0]  vs1, vs2;
    int          cnt;
    clk_i        = 1'b0;
    rst_n_i      = 1'b0;
    awaddr_i     = '0;
    araddr_i     = '0;
    wdata_i      = '0;
    wstrb_i      = '1;
    awvalid_i    = 1'b0;
    wvalid_i     = 1'b0;
    bready_i     = 1'b0;
    arvalid_i    = 1'b0;
    rready_i     = 1'b0;
    lfsr_q       = 32'h6dda_30c6;
    bp_en        = 1'b0;
    check_cnt    = 0;
    mismatch_cnt = 0;
    timeout_cnt  = 0;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    @(negedge clk_i);

    // Element write and read back
    for (int v = 0; v < `VEC_NR_VREGS; v++) begin
      for (int e = 0; e < `VEC_VLEN; e++) begin
        write_elem(v, e, rand_bits(32));
      end
    end
    for (int v = 0; v < `VEC_NR_VREGS; v++) begin
      check_reg(v);
    end

    // Every opcode on fresh sources
    for (int op = 0; op < 6; op++) begin
      vs1 = rand_bits(2);
      vs2 = rand_bits(2);
      for (int e = 0; e < `VEC_VLEN; e++) begin
        write_elem(vs1, e, rand_bits(32));
        write_elem(vs2, e, rand_bits(32));
      end
      run_cmd(op, rand_bits(2), vs1, vs2);
    end

    // Second command lands while the first still runs
    axi_write(`VEC_ADDR_CMD, cmd_word(3'd0, 2'd0, 2'd1, 2'd2), resp);
    expect_eq("first command resp", resp, resp_okay);
    axi_write(`VEC_ADDR_CMD, cmd_word(3'd4, 2'd3, 2'd1, 2'd2), resp);
    expect_eq("busy command resp", resp, resp_slverr);
    wait_idle();
    sum = apply_ref(3'd0, 2'd0, 2'd1, 2'd2);
    axi_read(`VEC_ADDR_RED, data, resp);
    expect_eq("sum after busy command", data, sum);
    check_reg(0);
    check_reg(3);

    // Element read and write while a command runs
    axi_write(`VEC_ADDR_CMD, cmd_word(3'd2, 2'd3, 2'd0, 2'd1), resp);
    expect_eq("third command resp", resp, resp_okay);
    axi_read(elem_addr(1, 5), data, resp);
    expect_eq("busy element read resp", resp, resp_slverr);
    axi_write(elem_addr(1, 5), 32'h5a5a_0ff0, resp);
    expect_eq("busy element write resp", resp, resp_slverr);
    wait_idle();
    sum = apply_ref(3'd2, 2'd3, 2'd0, 2'd1);
    axi_read(`VEC_ADDR_RED, data, resp);
    expect_eq("sum after busy element access", data, sum);
    check_reg(1);
    check_reg(3);

    // Illegal opcodes never start
    for (int op = 6; op < 8; op++) begin
      axi_write(`VEC_ADDR_CMD, cmd_word(op, 2'd1, 2'd2, 2'd3), resp);
      expect_eq($sformatf("illegal op %0d resp", op), resp, resp_slverr);
      axi_read(`VEC_ADDR_STATUS, data, resp);
      expect_eq($sformatf("status after op %0d", op), data, 32'h0);
    end
    check_reg(1);

    axi_write(12'h10C, 32'hdead_beef, resp);
    expect_eq("unmapped write resp", resp, resp_slverr);
    axi_read(12'h200, data, resp);
    expect_eq("unmapped read resp", resp, resp_slverr);
    axi_read(12'hFFC, data, resp);
    expect_eq("unmapped top read resp", resp, resp_slverr);

    // Same traffic with B and R stalled
    bp_en = 1'b1;
    for (int e = 0; e < `VEC_VLEN; e++) begin
      write_elem(1, e, rand_bits(32));
      write_elem(2, e, rand_bits(32));
    end
    run_cmd(3'd5, 2'd3, 2'd1, 2'd2);
    run_cmd(3'd1, 2'd0, 2'd3, 2'd2);
    for (int v = 0; v < `VEC_NR_VREGS; v++) begin
      check_reg(v);
    end
    bp_en = 1'b0;

    cnt = 0;
    while (got_q.size() != 0) begin
      cnt++;
      if (cnt > timeout_cycles) time_out("compare queue to drain");
      @(negedge clk_i);
    end
    report_counts();
    if (mismatch_cnt == 0 && dut_i.i_assertions.fail_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* vec_top.f */
+incdir+hw
hw/vec_pkg.sv
hw/vec_dispatcher.sv
hw/vec_lane.sv
hw/vec_reduce.sv
hw/vec_top.sv
tb/vec_top_assertions.sv
tb/tb_vec_top.sv

/* Bender.yml */
package:
  name: vec_top

sources:
  - include_dirs:
      - hw
    files:
      - hw/vec_pkg.sv
      - hw/vec_dispatcher.sv
      - hw/vec_lane.sv
      - hw/vec_reduce.sv
      - hw/vec_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tb/vec_top_assertions.sv
      - tb/tb_vec_top.sv
